//--- build.f
+incdir+verif
hw/muldiv_pkg.sv
hw/imul_iterative.sv
hw/idiv_iterative.sv
hw/imul_idiv_iterative.sv
hw/muldiv_req_fifo.sv
hw/muldiv_top.sv
verif/muldiv_tb.sv

//--- Bender.yml
package:
  name: muldiv

sources:
  # RTL in compile order
  - files:
      - hw/muldiv_pkg.sv
      - hw/imul_iterative.sv
      - hw/idiv_iterative.sv
      - hw/imul_idiv_iterative.sv
      - hw/muldiv_req_fifo.sv
      - hw/muldiv_top.sv

  # Testbench, top module muldiv_tb
  - target: test
    include_dirs:
      - verif
    files:
      - verif/muldiv_tb.sv

export_include_dirs:
  - verif

# Simulation top: muldiv_tb
# Synthesis top: muldiv_top

//--- verif/muldiv_ref.svh
//////////////////////////////////////////////////
// Mul/div reference model
// Expected result of one M-extension operation,
// worked out in 64-bit arithmetic
//////////////////////////////////////////////////

`ifndef MULDIV_REF_SVH
`define MULDIV_REF_SVH

function automatic logic [31:0] muldiv_ref(input muldiv_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
  logic signed [63:0] sa, sb, ua, ub, r;
  sa = {{32{a[31]}}, a};
  sb = {{32{b[31]}}, b};
  ua = {32'b0, a};
  ub = {32'b0, b};

  // Divide by zero
  if ((op == OP_DIV || op == OP_DIVU) && b == 32'h0) return 32'hffff_ffff;
  if ((op == OP_REM || op == OP_REMU) && b == 32'h0) return a;

  // Signed overflow, most negative over minus one
  if (a == 32'h8000_0000 && b == 32'hffff_ffff)
  begin
    if (op == OP_DIV) return a;
    if (op == OP_REM) return 32'h0;
  end

  case (op)
    OP_MUL:    begin r = ua * ub; return r[31:0];  end
    OP_MULH:   begin r = sa * sb; return r[63:32]; end
    OP_MULHSU: begin r = sa * ub; return r[63:32]; end
    OP_MULHU:  begin r = ua * ub; return r[63:32]; end
    OP_DIV:    begin r = sa / sb; return r[31:0];  end
    OP_DIVU:   begin r = ua / ub; return r[31:0];  end
    OP_REM:    begin r = sa % sb; return r[31:0];  end // Sign of dividend
    default:   begin r = ua % ub; return r[31:0];  end
  endcase
endfunction

`endif

//--- verif/muldiv_tb.sv
//////////////////////////////////////////////////
// Mul/div unit testbench
// Random and corner-case requests with yumi
// back-pressure, results checked in order
//////////////////////////////////////////////////

`timescale 1ns/1ps

module muldiv_tb
  import muldiv_pkg::*;
  ;

  localparam int          width_lp   = 32;
  localparam int          timeout_lp = 1000;  // Cycles per wait
  localparam logic [31:0] min_lp     = 32'h8000_0000;

  logic               clk_i, reset_i;
  logic               v_i, ready_o, v_o, yumi_i;
  muldiv_op_e         op_i;
  logic [width_lp-1:0] opa_i, opb_i, result_o;

  int                 seed = 94;
  int                 stall_seed;
  int                 stall_lvl;          // 0 accepts at once, higher stalls longer
  logic               hold_yumi;
  int                 accepted, returned, error_cnt;

  logic [31:0]        exp_q [$];
  muldiv_op_e         op_q  [$];
  logic               held_v;
  logic [31:0]        held_result;

  `include "muldiv_ref.svh"

  muldiv_top #(.width_p(width_lp)) UUT
    (.clk_i, .reset_i
    ,.v_i, .ready_o, .op_i, .opa_i, .opb_i
    ,.v_o, .result_o, .yumi_i
    );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Failure reporting and compares

  task automatic fail_run(input string msg);
    error_cnt++;
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at first failure");
  endtask

  task automatic check_result(input muldiv_op_e op, input logic [31:0] got,
                              input logic [31:0] exp, input string what);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %0t: %s for %s got %h expected %h",
                         $time, what, op.name(), got, exp));
  endtask

  task automatic check_handshake(input logic exp_ready, input logic exp_v,
                                 input string what);
    if (ready_o !== exp_ready || v_o !== exp_v)
      fail_run($sformatf("[ERROR] %0t: %s ready_o %b v_o %b expected %b %b",
                         $time, what, ready_o, v_o, exp_ready, exp_v));
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers

  // Caller sits on a rising edge
  task automatic send_req(input muldiv_op_e op, input logic [31:0] a, input logic [31:0] b);
    int waited;
    v_i    <= 1'b1;
    op_i   <= op;
    opa_i  <= a;
    opb_i  <= b;
    waited = 0;
    do
    begin
      @(posedge clk_i);
      waited++;
      if (waited > timeout_lp)
        fail_run("Timed out waiting for the unit to accept a request");
    end
    while (!ready_o);
    v_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (returned != accepted)
    begin
      @(posedge clk_i);
      waited++;
      if (waited > timeout_lp)
        fail_run("Timed out waiting for outstanding results to return");
    end
  endtask

  function automatic logic [31:0] rand_operand();
    logic [31:0] r;
    r = $random(seed);
    case (r[2:0])
      3'd0:    return 32'h0;
      3'd1:    return min_lp;
      3'd2:    return 32'hffff_ffff;
      3'd3:    return {28'h0, r[7:4]};       // Small positive
      3'd4:    return -{28'h0, r[7:4]};      // Small negative
      default: return $random(seed);
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Consumer side, yumi only after v_o was seen
  always @(posedge clk_i)
  begin
    if (reset_i)
      yumi_i <= 1'b0;
    else if (v_o && !yumi_i && !hold_yumi && (($random(stall_seed) & 127) >= stall_lvl))
      yumi_i <= 1'b1;
    else
      yumi_i <= 1'b0;
  end

  //////////////////////////////////////////////////
  // Monitor and compare
  always @(posedge clk_i)
  begin
    if (reset_i)
      held_v = 1'b0;
    else
    begin
      if (held_v)
      begin
        if (!v_o)
          fail_run($sformatf("[ERROR] %0t: result withdrawn without yumi", $time));
        check_result(op_q[0], result_o, held_result, "held result");
      end
      if (v_o && exp_q.size() == 0)
        fail_run($sformatf("[ERROR] %0t: result with no request outstanding", $time));
      if (v_o && yumi_i)
      begin
        check_result(op_q[0], result_o, exp_q[0], "returned result");
        void'(exp_q.pop_front());
        void'(op_q.pop_front());
        returned++;
      end
      if (v_i && ready_o)
      begin
        exp_q.push_back(muldiv_ref(op_i, opa_i, opb_i));
        op_q.push_back(op_i);
        accepted++;
      end
      if (accepted - returned > 3)
        fail_run($sformatf("[ERROR] %0t: %0d requests in flight", $time, accepted - returned));
      held_v      = v_o && !yumi_i;
      held_result = result_o;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  initial
  begin
    logic [31:0] a, b, r;
    int          waited;
    reset_i    = 1'b1;
    v_i        = 1'b0;
    op_i       = OP_MUL;
    opa_i      = '0;
    opb_i      = '0;
    yumi_i     = 1'b0;
    hold_yumi  = 1'b0;
    stall_lvl  = 0;
    stall_seed = seed + 1;
    accepted   = 0;
    returned   = 0;
    error_cnt  = 0;

    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    repeat (5)
    begin
      @(posedge clk_i);
      check_handshake(1'b1, 1'b0, "idle after reset");
    end

    // Every opcode with random operands
    for (int op = 0; op < 8; op++)
      for (int n = 0; n < 6; n++)
        send_req(muldiv_op_e'(op), rand_operand(), rand_operand());
    wait_drain();

    // Corner cases
    send_req(OP_DIV, 32'h1234_5678, 32'h0);
    send_req(OP_DIVU, min_lp, 32'h0);
    send_req(OP_REM, 32'hfedc_ba98, 32'h0);
    send_req(OP_REMU, 32'h0000_0007, 32'h0);
    send_req(OP_DIV, min_lp, 32'hffff_ffff);
    send_req(OP_REM, min_lp, 32'hffff_ffff);
    send_req(OP_MULH, min_lp, min_lp);
    send_req(OP_MULH, min_lp, 32'hffff_ffff);
    send_req(OP_MULHSU, min_lp, 32'hffff_ffff);
    send_req(OP_MULHSU, min_lp, min_lp);
    wait_drain();

    // Back-to-back traffic with random yumi stalls
    for (int i = 0; i < 300; i++)
    begin
      r = $random(seed);
      if (i % 32 == 0)
        stall_lvl <= r[8] ? 0 : 100;
      send_req(muldiv_op_e'(r[2:0]), rand_operand(), rand_operand());
      if (r[5:4] == 2'b00)
        repeat (r[11:9]) @(posedge clk_i);
    end
    wait_drain();

    // Fill the buffer behind a stalled result
    stall_lvl <= 0;
    hold_yumi <= 1'b1;
    for (int n = 0; n < 3; n++)
      send_req(OP_MULHU, rand_operand(), rand_operand());
    a = rand_operand();
    b = rand_operand();
    v_i   <= 1'b1;
    op_i  <= OP_REM;
    opa_i <= a;
    opb_i <= b;
    waited = 0;
    do
    begin
      @(posedge clk_i);
      waited++;
      if (waited > timeout_lp)
        fail_run("Timed out waiting for the stalled result to appear");
    end
    while (!v_o);
    repeat (20)
    begin
      @(posedge clk_i);
      check_handshake(1'b0, 1'b1, "full buffer with stalled result");
      if (accepted - returned != 3)
        fail_run($sformatf("[ERROR] %0t: request accepted while buffer full", $time));
    end
    hold_yumi <= 1'b0;
    send_req(OP_REM, a, b);
    wait_drain();

    repeat (5) @(posedge clk_i);
    if (error_cnt == 0)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
    begin
      $display("STATUS: FAIL");
      $fatal(1, "Errors recorded during the run");
    end
  end

endmodule

//--- hw/muldiv_top.sv
//////////////////////////////////////////////////
// Mul/div unit top level
// Request buffer feeding the iterative front end
//////////////////////////////////////////////////

`timescale 1ns/1ps

module muldiv_top
  import muldiv_pkg::*;
  #(parameter int width_p = muldiv_width_c
  )
  ( input                      clk_i
  , input                      reset_i

  , input                      v_i
  , output logic               ready_o
  , input  muldiv_op_e         op_i
  , input        [width_p-1:0] opa_i
  , input        [width_p-1:0] opb_i

  , output logic               v_o
  , output logic [width_p-1:0] result_o
  , input                      yumi_i
  );

  logic               fifo_v, fe_ready, fifo_yumi;
  muldiv_op_e         fifo_op;
  logic [width_p-1:0] fifo_opa, fifo_opb;

  assign fifo_yumi = fifo_v & fe_ready; // Head taken by the front end

  muldiv_req_fifo #(.width_p(width_p)) req_fifo
    (.clk_i, .reset_i
    ,.v_i, .op_i, .opa_i, .opb_i, .ready_o
    ,.v_o(fifo_v), .op_o(fifo_op), .opa_o(fifo_opa), .opb_o(fifo_opb)
    ,.yumi_i(fifo_yumi)
    );

  imul_idiv_iterative #(.width_p(width_p)) muldiv
    (.clk_i, .reset_i
    ,.v_i(fifo_v), .ready_o(fe_ready), .op_i(fifo_op)
    ,.opa_i(fifo_opa), .opb_i(fifo_opb)
    ,.v_o, .result_o, .yumi_i
    );

endmodule

//--- hw/muldiv_req_fifo.sv
//////////////////////////////////////////////////
// Mul/div request buffer
// Two-entry FIFO between issue and the front end
//////////////////////////////////////////////////

`timescale 1ns/1ps

module muldiv_req_fifo
  import muldiv_pkg::*;
  #(parameter int width_p = muldiv_width_c
  )
  ( input                      clk_i
  , input                      reset_i

  , input                      v_i
  , input  muldiv_op_e         op_i
  , input        [width_p-1:0] opa_i
  , input        [width_p-1:0] opb_i
  , output logic               ready_o

  , output logic               v_o
  , output muldiv_op_e         op_o
  , output logic [width_p-1:0] opa_o
  , output logic [width_p-1:0] opb_o
  , input                      yumi_i
  );

  muldiv_op_e         op_mem  [2];
  logic [width_p-1:0] opa_mem [2];
  logic [width_p-1:0] opb_mem [2];

  logic wr_ptr_r, rd_ptr_r;
  logic full_r;                          // Tells full from empty on equal pointers
  logic enq, ptr_eq;

  assign ptr_eq  = (wr_ptr_r == rd_ptr_r);
  assign ready_o = ~(ptr_eq & full_r);
  assign v_o     = ~(ptr_eq & ~full_r);
  assign enq     = v_i & ready_o;

  assign op_o  = op_mem[rd_ptr_r];
  assign opa_o = opa_mem[rd_ptr_r];
  assign opb_o = opb_mem[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
    end
    else
    begin
      if (enq)    wr_ptr_r <= ~wr_ptr_r;
      if (yumi_i) rd_ptr_r <= ~rd_ptr_r;
      if (enq && !yumi_i)
        full_r <= (~wr_ptr_r == rd_ptr_r); // Second entry taken
      else if (yumi_i && !enq)
        full_r <= 1'b0;
    end
  end

  // Storage
  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      op_mem[wr_ptr_r]  <= op_i;
      opa_mem[wr_ptr_r] <= opa_i;
      opb_mem[wr_ptr_r] <= opb_i;
    end
  end

  yumi_on_valid_a: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o)
    else $error("request buffer dequeued while empty");

endmodule

//--- hw/imul_idiv_iterative.sv
//////////////////////////////////////////////////
// Mul/div front end
// Decodes funct3, starts one engine and returns
// product, quotient or remainder
//////////////////////////////////////////////////

`timescale 1ns/1ps

module imul_idiv_iterative
  import muldiv_pkg::*;
  #(parameter int width_p = muldiv_width_c
  )
  ( input                      clk_i
  , input                      reset_i

  , input                      v_i
  , output logic               ready_o
  , input  muldiv_op_e         op_i
  , input        [width_p-1:0] opa_i
  , input        [width_p-1:0] opb_i

  , output logic               v_o
  , output logic [width_p-1:0] result_o
  , input                      yumi_i
  );

  logic               imul_v, signed_opa, signed_opb, gets_high_part;
  logic               idiv_v, signed_div, gets_quotient;
  logic               imul_ready, imul_v_o, idiv_ready, idiv_v_o;
  logic               gets_quotient_r;
  logic [width_p-1:0] imul_result, quotient, remainder;
  logic               start;

  assign ready_o = imul_ready & idiv_ready;
  assign start   = v_i & ready_o; // Only when both engines idle

  //////////////////////////////////////////////////
  // Decode
  always_comb
  begin
    imul_v         = 1'b0;
    signed_opa     = 1'b0;
    signed_opb     = 1'b0;
    gets_high_part = 1'b0;
    idiv_v         = 1'b0;
    signed_div     = 1'b0;
    gets_quotient  = 1'b0;

    unique case (op_i)
      OP_MUL:    begin imul_v = start; end
      OP_MULH:
      begin
        imul_v         = start;
        signed_opa     = 1'b1;
        signed_opb     = 1'b1;
        gets_high_part = 1'b1;
      end
      OP_MULHSU:
      begin
        imul_v         = start;
        signed_opa     = 1'b1;
        gets_high_part = 1'b1;
      end
      OP_MULHU:  begin imul_v = start; gets_high_part = 1'b1; end
      OP_DIV:    begin idiv_v = start; signed_div = 1'b1; gets_quotient = 1'b1; end
      OP_DIVU:   begin idiv_v = start; gets_quotient = 1'b1; end
      OP_REM:    begin idiv_v = start; signed_div = 1'b1; end
      OP_REMU:   begin idiv_v = start; end
      default:   ;
    endcase
  end

  imul_iterative #(.width_p(width_p)) imul
    (.clk_i, .reset_i
    ,.v_i(imul_v), .ready_o(imul_ready)
    ,.opa_i, .signed_opa_i(signed_opa), .opb_i, .signed_opb_i(signed_opb)
    ,.gets_high_part_i(gets_high_part)
    ,.v_o(imul_v_o), .result_o(imul_result), .yumi_i
    );

  idiv_iterative #(.width_p(width_p)) idiv
    (.clk_i, .reset_i
    ,.v_i(idiv_v), .ready_o(idiv_ready)
    ,.dividend_i(opa_i), .divisor_i(opb_i), .signed_div_i(signed_div)
    ,.v_o(idiv_v_o), .quotient_o(quotient), .remainder_o(remainder), .yumi_i
    );

  //////////////////////////////////////////////////
  // Result select
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      gets_quotient_r <= 1'b0;
    else if (idiv_v)
      gets_quotient_r <= gets_quotient;
  end

  assign v_o      = imul_v_o | idiv_v_o;
  assign result_o = imul_v_o ? imul_result : (gets_quotient_r ? quotient : remainder);

  // One operation in flight across both engines
  one_engine_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(imul_v_o && idiv_v_o))
    else $error("both engines report a result");

endmodule

//--- hw/idiv_iterative.sv
//////////////////////////////////////////////////
// Iterative restoring divider
// Magnitude division one bit per cycle, then
// sign correction and RISC-V corner cases
//////////////////////////////////////////////////

`timescale 1ns/1ps

module idiv_iterative
  import muldiv_pkg::*;
  #(parameter int width_p = muldiv_width_c
  )
  ( input                      clk_i
  , input                      reset_i

  , input                      v_i
  , output logic               ready_o

  , input        [width_p-1:0] dividend_i
  , input        [width_p-1:0] divisor_i
  , input                      signed_div_i

  , output logic               v_o
  , output logic [width_p-1:0] quotient_o
  , output logic [width_p-1:0] remainder_o
  , input                      yumi_i
  );

  localparam int cnt_width_lp = $clog2(width_p + 1);

  typedef enum logic [1:0] {IDLE, CALC, FIX, DONE} idiv_state_e;

  idiv_state_e               state_r;
  logic [cnt_width_lp-1:0]   cnt_r;
  logic                      fix_step_r;

  logic [width_p-1:0]        dvnd_r;   // Raw dividend, kept for corner cases
  logic [width_p-1:0]        dvsr_r;   // Raw divisor, then its magnitude
  logic [width_p-1:0]        quo_r;
  logic [width_p:0]          rem_r;
  logic                      signed_r, neg_quo_r, neg_rem_r;
  logic                      zero_r, ovf_r;

  logic [width_p:0]          shifted, diff;

  assign ready_o     = (state_r == IDLE);
  assign v_o         = (state_r == DONE);
  assign quotient_o  = quo_r;
  assign remainder_o = rem_r[width_p-1:0];

  // One restoring step
  assign shifted = {rem_r[width_p-1:0], quo_r[width_p-1]};
  assign diff    = shifted - {1'b0, dvsr_r};

  //////////////////////////////////////////////////
  // Control
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r    <= IDLE;
      cnt_r      <= '0;
      fix_step_r <= 1'b0;
    end
    else
    begin
      case (state_r)
        IDLE: if (v_i)
        begin
          state_r <= CALC;
          cnt_r   <= '0;
        end
        CALC:
        begin
          cnt_r <= cnt_r + 1'b1;
          if (cnt_r == cnt_width_lp'(width_p))
          begin
            state_r    <= FIX;
            fix_step_r <= 1'b0;
          end
        end
        FIX:
        begin
          fix_step_r <= 1'b1;
          if (fix_step_r) state_r <= DONE;
        end
        DONE: if (yumi_i) state_r <= IDLE;
        default: state_r <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  always_ff @(posedge clk_i)
  begin
    case (state_r)
      IDLE: if (v_i)
      begin
        dvnd_r    <= dividend_i;
        dvsr_r    <= divisor_i;
        signed_r  <= signed_div_i;
        neg_quo_r <= signed_div_i & (dividend_i[width_p-1] ^ divisor_i[width_p-1]);
        neg_rem_r <= signed_div_i & dividend_i[width_p-1];
        zero_r    <= (divisor_i == '0);
        ovf_r     <= signed_div_i & (dividend_i == {1'b1, {(width_p-1){1'b0}}})
                     & (divisor_i == '1);
      end
      CALC:
      begin
        if (cnt_r == '0)
        begin
          // Setup step, take magnitudes
          quo_r  <= neg_rem_r ? -dvnd_r : dvnd_r;
          dvsr_r <= (signed_r & dvsr_r[width_p-1]) ? -dvsr_r : dvsr_r;
          rem_r  <= '0;
        end
        else
        begin
          quo_r <= {quo_r[width_p-2:0], ~diff[width_p]};
          rem_r <= diff[width_p] ? shifted : diff; // Restore on borrow
        end
      end
      FIX:
      begin
        if (!fix_step_r)
        begin
          quo_r <= neg_quo_r ? -quo_r : quo_r;
          rem_r <= {1'b0, (neg_rem_r ? -rem_r[width_p-1:0] : rem_r[width_p-1:0])};
        end
        else if (zero_r)
        begin
          quo_r <= '1;
          rem_r <= {1'b0, dvnd_r};
        end
        else if (ovf_r)
        begin
          quo_r <= dvnd_r; // Most negative over minus one
          rem_r <= '0;
        end
      end
      default: ;
    endcase
  end

  // Busy and done are exclusive phases
  v_ready_excl_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(v_o && ready_o))
    else $error("idiv raised v_o while ready");

endmodule

//--- hw/imul_iterative.sv
//////////////////////////////////////////////////
// Iterative shift-add multiplier
// One partial product per cycle on magnitudes,
// sign fixed afterwards, high or low half out
//////////////////////////////////////////////////

`timescale 1ns/1ps

module imul_iterative
  import muldiv_pkg::*;
  #(parameter int width_p = muldiv_width_c
  )
  ( input                      clk_i
  , input                      reset_i

  , input                      v_i
  , output logic               ready_o

  , input        [width_p-1:0] opa_i
  , input                      signed_opa_i
  , input        [width_p-1:0] opb_i
  , input                      signed_opb_i
  , input                      gets_high_part_i

  , output logic               v_o
  , output logic [width_p-1:0] result_o
  , input                      yumi_i
  );

  localparam int cnt_width_lp = $clog2(width_p + 2);

  typedef enum logic [1:0] {IDLE, CALC, DONE} imul_state_e;

  imul_state_e               state_r;
  logic [cnt_width_lp-1:0]   cnt_r;
  logic [2*width_p-1:0]      prod_r, mcand_r;
  logic [width_p-1:0]        mplier_r;
  logic                      neg_r, high_r;
  logic                      neg_a, neg_b;

  assign ready_o = (state_r == IDLE);
  assign v_o     = (state_r == DONE);
  assign neg_a   = signed_opa_i & opa_i[width_p-1];
  assign neg_b   = signed_opb_i & opb_i[width_p-1];

  //////////////////////////////////////////////////
  // Control
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= IDLE;
      cnt_r   <= '0;
    end
    else
    begin
      case (state_r)
        IDLE: if (v_i)
        begin
          state_r <= CALC;
          cnt_r   <= '0;
        end
        CALC:
        begin
          cnt_r <= cnt_r + 1'b1;
          if (cnt_r == cnt_width_lp'(width_p + 1))
            state_r <= DONE; // Product selected this edge
        end
        DONE: if (yumi_i) state_r <= IDLE;
        default: state_r <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  always_ff @(posedge clk_i)
  begin
    if (state_r == IDLE && v_i)
    begin
      mcand_r  <= {{width_p{1'b0}}, (neg_a ? -opa_i : opa_i)};
      mplier_r <= neg_b ? -opb_i : opb_i;
      prod_r   <= '0;
      neg_r    <= neg_a ^ neg_b;
      high_r   <= gets_high_part_i;
    end
    else if (state_r == CALC)
    begin
      if (cnt_r < cnt_width_lp'(width_p))
      begin
        if (mplier_r[0])
          prod_r <= prod_r + mcand_r;
        mcand_r  <= mcand_r << 1;
        mplier_r <= mplier_r >> 1;
      end
      else if (cnt_r == cnt_width_lp'(width_p))
        prod_r <= neg_r ? -prod_r : prod_r; // Restore sign
      else
        result_o <= high_r ? prod_r[2*width_p-1:width_p] : prod_r[width_p-1:0];
    end
  end

  // A finished product waits for yumi and does not change
  done_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == DONE && !yumi_i) |=> (state_r == DONE && $stable(result_o)))
    else $error("imul left DONE or changed result without yumi");

endmodule

//--- hw/muldiv_pkg.sv
//////////////////////////////////////////////////
// Mul/div shared definitions
// RISC-V M-extension funct3 opcodes and the
// default operand width for the iterative unit
//////////////////////////////////////////////////

package muldiv_pkg;

  //////////////////////////////////////////////////
  // Widths

  // Default operand and result width, one word
  localparam int muldiv_width_c = 32;

  // funct3 field of the OP/M instructions
  localparam int muldiv_op_width_c = 3;

  //////////////////////////////////////////////////
  // Opcodes

  // Encoding follows funct3 of the M extension
  typedef enum logic [muldiv_op_width_c-1:0] {
    OP_MUL    = 3'd0, // Low half, sign irrelevant
    OP_MULH   = 3'd1, // High half, signed x signed
    OP_MULHSU = 3'd2, // High half, signed x unsigned
    OP_MULHU  = 3'd3, // High half, unsigned x unsigned
    OP_DIV    = 3'd4, // Signed quotient
    OP_DIVU   = 3'd5, // Unsigned quotient
    OP_REM    = 3'd6, // Signed remainder, sign of dividend
    OP_REMU   = 3'd7  // Unsigned remainder
  } muldiv_op_e;

  // Upper funct3 bit splits the two engines
  // 0 goes to the multiplier, 1 to the divider

  // Divide by zero gives all ones / dividend
  // Signed overflow gives dividend / zero

endpackage
